// File: bench/fp_control_tb.sv
// testbench for fp_control_top; needs --timing and --assert, random jobs from a fixed LFSR seed
`timescale 1ns/100ps
`include "fp_control_params.svh"

module fp_control_tb;

	localparam int JOBS = 24;
	localparam int JOB_TIMEOUT = 80;

	logic                got_fp;
	logic                _0_f;
	logic                efp;
	fp_op_pkg::op_code_t op;
	fp_op_pkg::fp_cond_t cond;
	fp_ctl_pkg::fp_ctl_t ctl;
	logic                ekc_fp;

	logic [31:0] lfsr;
	int          err_cnt = 0;
	int          job_no;
	logic        job_on;
	int          jobs_done;
	logic        timed_out;

	// expected totals of the running job
	int exp_al;
	int exp_ar;
	int exp_md;
	int exp_nm;
	int exp_ct;

	// observed totals, cleared once ekc_fp is seen
	int   rd_cnt;
	int   st_cnt;
	int   al_cnt;
	int   ar_cnt;
	int   md_cnt;
	int   nm_cnt;
	int   ct_cnt;
	logic st_prev;
	logic ek_prev;

	fp_control_top DUT (
		.got_fp (got_fp),
		._0_f   (_0_f),
		.efp    (efp),
		.op     (op),
		.cond   (cond),
		.ctl    (ctl),
		.ekc_fp (ekc_fp)
	);

	initial begin
		got_fp = 1'b0;
		forever begin
			#50 got_fp = ~got_fp;
		end
	end

	// ------------------------------------------------------------
	// random source, x^32 + x^22 + x^2 + x + 1
	// ------------------------------------------------------------

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic draw_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
	endtask

	// ------------------------------------------------------------
	// per job counters of the control levels
	// ------------------------------------------------------------

	always @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			rd_cnt <= 0;
			st_cnt <= 0;
			al_cnt <= 0;
			ar_cnt <= 0;
			md_cnt <= 0;
			nm_cnt <= 0;
			ct_cnt <= 0;
			st_prev <= 1'b0;
			ek_prev <= 1'b0;
		end else begin
			st_prev <= ctl.store_fp;
			ek_prev <= ekc_fp;
			if (ekc_fp) begin
				rd_cnt <= 0;
				st_cnt <= 0;
				al_cnt <= 0;
				ar_cnt <= 0;
				md_cnt <= 0;
				nm_cnt <= 0;
				ct_cnt <= 0;
			end else begin
				rd_cnt <= rd_cnt + int'(ctl.read_fp);
				st_cnt <= st_cnt + int'(ctl.store_fp);
				al_cnt <= al_cnt + int'(ctl.shift_align);
				ar_cnt <= ar_cnt + int'(ctl.arith_step);
				md_cnt <= md_cnt + int'(ctl.mul_div);
				nm_cnt <= nm_cnt + int'(ctl.shift_norm);
				ct_cnt <= ct_cnt + int'(ctl.clear_t);
			end
		end
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------

	// reset included, nothing moves before efp
	idle_quiet: assert property (@(posedge got_fp) !job_on |-> (ctl == '0 && !ekc_fp))
		else begin
			err_cnt++;
			$display("[FAIL] job %0d idle_quiet: expected ctl 0 ekc_fp 0, actual ctl %h ekc_fp %b",
				job_no, $sampled(ctl), $sampled(ekc_fp));
		end

	read_order: assert property (@(posedge got_fp) disable iff (_0_f)
		ctl.read_fp |-> (int'(ctl.word_sel) == rd_cnt && rd_cnt < `FP_WORDS))
		else begin
			err_cnt++;
			$display("[FAIL] job %0d read_order: expected word_sel %0d, actual %0d",
				job_no, $sampled(rd_cnt), $sampled(ctl.word_sel));
		end

	store_order: assert property (@(posedge got_fp) disable iff (_0_f)
		ctl.store_fp |-> (int'(ctl.word_sel) == st_cnt && rd_cnt == `FP_WORDS))
		else begin
			err_cnt++;
			$display("[FAIL] job %0d store_order: expected word_sel %0d, actual %0d",
				job_no, $sampled(st_cnt), $sampled(ctl.word_sel));
		end

	rd_st_apart: assert property (@(posedge got_fp) disable iff (_0_f)
		!(ctl.read_fp && ctl.store_fp))
		else begin
			err_cnt++;
			$display("job %0d: read_fp and store_fp were high in the same cycle", job_no);
		end

	align_count: assert property (@(posedge got_fp) disable iff (_0_f)
		ctl.shift_align |-> al_cnt < exp_al)
		else begin
			err_cnt++;
			$display("[FAIL] job %0d align_count: expected %0d shift_align cycles, actual %0d",
				job_no, exp_al, $sampled(al_cnt) + 1);
		end

	arith_run: assert property (@(posedge got_fp) disable iff (_0_f)
		(ar_cnt != 0 && ar_cnt < exp_ar) |-> ctl.arith_step)
		else begin
			err_cnt++;
			$display("job %0d: arith_step dropped after %0d of %0d cycles",
				job_no, $sampled(ar_cnt), exp_ar);
		end

	arith_limit: assert property (@(posedge got_fp) disable iff (_0_f)
		ctl.arith_step |-> ar_cnt < exp_ar)
		else begin
			err_cnt++;
			$display("[FAIL] job %0d arith_limit: expected %0d arith_step cycles, actual %0d",
				job_no, exp_ar, $sampled(ar_cnt) + 1);
		end

	mul_div_level: assert property (@(posedge got_fp) disable iff (_0_f)
		ctl.mul_div == (ctl.arith_step && exp_md != 0))
		else begin
			err_cnt++;
			$display("[FAIL] job %0d mul_div_level: expected %b, actual %b",
				job_no, $sampled(ctl.arith_step) && exp_md != 0, $sampled(ctl.mul_div));
		end

	clear_first: assert property (@(posedge got_fp) disable iff (_0_f)
		ctl.clear_t == (ctl.arith_step && ar_cnt == 0))
		else begin
			err_cnt++;
			$display("[FAIL] job %0d clear_first: expected %b, actual %b", job_no,
				$sampled(ctl.arith_step) && $sampled(ar_cnt) == 0, $sampled(ctl.clear_t));
		end

	norm_count: assert property (@(posedge got_fp) disable iff (_0_f)
		ctl.shift_norm |-> nm_cnt < exp_nm)
		else begin
			err_cnt++;
			$display("[FAIL] job %0d norm_count: expected %0d shift_norm cycles, actual %0d",
				job_no, exp_nm, $sampled(nm_cnt) + 1);
		end

	// single pulse right behind the last store word
	end_pulse: assert property (@(posedge got_fp) disable iff (_0_f)
		ekc_fp |-> (st_prev && !ek_prev && st_cnt == `FP_WORDS))
		else begin
			err_cnt++;
			$display("job %0d: ekc_fp was not a single pulse right after the last store", job_no);
		end

	end_totals: assert property (@(posedge got_fp) disable iff (_0_f)
		ekc_fp |-> (rd_cnt == `FP_WORDS && al_cnt == exp_al && ar_cnt == exp_ar &&
			md_cnt == exp_md && nm_cnt == exp_nm && ct_cnt == exp_ct))
		else begin
			err_cnt++;
			$write("[FAIL] job %0d end_totals: expected rd/al/ar/md/nm/ct %0d/%0d/%0d/%0d/%0d/%0d,",
				job_no, `FP_WORDS, exp_al, exp_ar, exp_md, exp_nm, exp_ct);
			$display(" actual %0d/%0d/%0d/%0d/%0d/%0d", $sampled(rd_cnt), $sampled(al_cnt),
				$sampled(ar_cnt), $sampled(md_cnt), $sampled(nm_cnt), $sampled(ct_cnt));
		end

	// ------------------------------------------------------------
	// one job, efp held high until ekc_fp
	// ------------------------------------------------------------

	task automatic run_job(input int n, output logic stalled);
		fp_op_pkg::op_code_t op_v;
		fp_op_pkg::fp_cond_t c;
		int   v;
		int   al_wait;
		int   nm_wait;
		int   gap;
		int   cyc;
		int   err_at;
		logic done;
		logic addsub;
		logic muldiv;
		draw_bits(3, v);
		op_v = (n < 5) ? fp_op_pkg::op_code_t'(n) : fp_op_pkg::op_code_t'(v);
		draw_bits(2, al_wait);
		draw_bits(2, nm_wait);
		draw_bits(1, v);
		c.zero = v[0];
		draw_bits(1, v);
		c.sgn = v[0];
		draw_bits(2, gap);
		c.aligned = (al_wait == 0);
		c.normal = (nm_wait == 0);
		addsub = (op_v == `FP_OP_AD) || (op_v == `FP_OP_SB);
		muldiv = (op_v == `FP_OP_MW) || (op_v == `FP_OP_DW);
		err_at = err_cnt;
		repeat (gap) @(posedge got_fp);
		@(posedge got_fp);
		job_no <= n;
		exp_al <= addsub ? al_wait : 0;
		exp_ar <= addsub ? 1 : (muldiv ? `FP_ITER : 0);
		exp_md <= muldiv ? `FP_ITER : 0;
		exp_nm <= c.zero ? 0 : nm_wait;
		exp_ct <= (addsub || muldiv) ? 1 : 0;
		job_on <= 1'b1;
		efp <= 1'b1;
		op <= op_v;
		cond <= c;
		done = 1'b0;
		cyc = 0;
		while (!done && cyc < JOB_TIMEOUT) begin
			@(negedge got_fp);
			// flags rise once the wanted number of shifts has gone by
			c.aligned = (al_cnt + int'(ctl.shift_align)) >= al_wait;
			c.normal = (nm_cnt + int'(ctl.shift_norm)) >= nm_wait;
			done = ekc_fp;
			cyc++;
			@(posedge got_fp);
			cond <= c;
			if (done) begin
				efp <= 1'b0;
				job_on <= 1'b0;
			end
		end
		stalled = !done;
		if (!done) begin
			$display("timeout: job %0d saw no ekc_fp within %0d cycles", n, JOB_TIMEOUT);
		end else begin
			@(negedge got_fp);
			$display("job %0d op %0d align %0d norm %0d zero %b: %0d errors",
				n, op_v, al_wait, nm_wait, c.zero, err_cnt - err_at);
		end
	endtask

	initial begin
		_0_f = 1'b1;
		efp = 1'b0;
		op = `FP_OP_AD;
		cond = fp_op_pkg::FP_COND_NONE;
		job_on = 1'b0;
		job_no = 0;
		jobs_done = 0;
		timed_out = 1'b0;
		lfsr = 32'h63ed;
		exp_al = 0;
		exp_ar = 0;
		exp_md = 0;
		exp_nm = 0;
		exp_ct = 0;
		repeat (10) @(posedge got_fp);
		_0_f <= 1'b0;
		while (jobs_done < JOBS && !timed_out) begin
			run_job(jobs_done, timed_out);
			jobs_done++;
		end
		$display("jobs %0d, errors %0d", jobs_done, err_cnt);
		if (err_cnt == 0 && !timed_out) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: design/fp_control_decode.sv
// control word decoder; outputs are combinational from phase, loop status and cond levels
`timescale 1ns/100ps
`include "fp_control_params.svh"

module fp_control_decode (
	input  logic                  got_fp,
	input  logic                  _0_f,
	input  fp_ctl_pkg::fp_state_t state,
	input  fp_op_pkg::op_code_t   op,
	input  fp_op_pkg::fp_cond_t   cond,
	input  fp_ctl_pkg::fp_loop_t  loop,
	output fp_ctl_pkg::fp_ctl_t   ctl
);

	fp_op_pkg::op_code_t   op_q;
	logic                  arith_seen_q;
	logic                  norm_seen_q;
	logic                  is_muldiv;
	logic                  norm_zero;
	fp_ctl_pkg::lp_index_t word_idx;

	// ------------------------------------------------------------
	// job op and phase history
	// ------------------------------------------------------------

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			op_q <= `FP_OP_AD;
			arith_seen_q <= 1'b0;
			norm_seen_q <= 1'b0;
		end else begin
			// tracks op while idle, frozen once the load starts
			if (state == fp_ctl_pkg::S_IDLE) begin
				op_q <= op;
			end
			arith_seen_q <= (state == fp_ctl_pkg::S_ARITH);
			norm_seen_q <= (state == fp_ctl_pkg::S_NORM);
		end
	end

	assign is_muldiv = (op_q == `FP_OP_MW) || (op_q == `FP_OP_DW);

	// zero on entry skips the normalize shifts
	assign norm_zero = cond.zero & ~norm_seen_q;

	// word order 0, 1, 2 while LP counts down
	assign word_idx = fp_ctl_pkg::lp_index_t'(`FP_WORDS - 1) - loop.idx;

	// ------------------------------------------------------------
	// control levels
	// ------------------------------------------------------------

	always_comb begin
		ctl = '0;
		case (state)
			fp_ctl_pkg::S_LOAD: begin
				ctl.read_fp = 1'b1;
				ctl.word_sel = loop.busy ? fp_ctl_pkg::word_sel_t'(word_idx) : '0;
			end
			fp_ctl_pkg::S_ALIGN: begin
				ctl.shift_align = ~cond.aligned;
			end
			fp_ctl_pkg::S_ARITH: begin
				ctl.arith_step = 1'b1;
				ctl.mul_div = is_muldiv;
				// T result cleared once per job
				ctl.clear_t = ~arith_seen_q;
			end
			fp_ctl_pkg::S_NORM: begin
				ctl.shift_norm = ~cond.normal & ~norm_zero;
			end
			fp_ctl_pkg::S_STORE: begin
				ctl.store_fp = 1'b1;
				ctl.word_sel = loop.busy ? fp_ctl_pkg::word_sel_t'(word_idx) : '0;
			end
			default: begin
				ctl = '0;
			end
		endcase
	end

endmodule

// File: design/fp_control_params.svh
// sizes and op codes for the fp control unit; FP_LP_BITS must hold FP_ITER-1 and FP_WORDS-1
`ifndef FP_CONTROL_PARAMS_SVH
`define FP_CONTROL_PARAMS_SVH

// operand and result words moved per transfer
`define FP_WORDS 3

// multiply and divide loop steps
`define FP_ITER 8

// loop counter width
`define FP_LP_BITS 4

// ------------------------------------------------------------
// operation codes
// ------------------------------------------------------------
`define FP_OP_AD 3'd0
`define FP_OP_SB 3'd1
`define FP_OP_MW 3'd2
`define FP_OP_DW 3'd3
`define FP_OP_NR 3'd4

`endif

// File: design/fp_control_top.sv
// fp control top; no output registers, ctl and ekc_fp follow the block registers directly
`timescale 1ns/100ps

module fp_control_top (
	input  logic                got_fp,
	input  logic                _0_f,
	input  logic                efp,
	input  fp_op_pkg::op_code_t op,
	input  fp_op_pkg::fp_cond_t cond,
	output fp_ctl_pkg::fp_ctl_t ctl,
	output logic                ekc_fp
);

	fp_ctl_pkg::fp_state_t state;
	fp_ctl_pkg::lp_load_t  lp_load;
	fp_ctl_pkg::fp_loop_t  loop;

	// ------------------------------------------------------------
	// phase chain
	// ------------------------------------------------------------

	fp_state_seq u_seq (
		.got_fp  (got_fp),
		._0_f    (_0_f),
		.efp     (efp),
		.op      (op),
		.cond    (cond),
		.loop    (loop),
		.state   (state),
		.lp_load (lp_load),
		.ekc_fp  (ekc_fp)
	);

	// LP counter, runs beside the sequencer
	fp_loop_counter u_lp (
		.got_fp  (got_fp),
		._0_f    (_0_f),
		.lp_load (lp_load),
		.loop    (loop)
	);

	// ------------------------------------------------------------
	// control word
	// ------------------------------------------------------------

	fp_control_decode u_dec (
		.got_fp (got_fp),
		._0_f   (_0_f),
		.state  (state),
		.op     (op),
		.cond   (cond),
		.loop   (loop),
		.ctl    (ctl)
	);

endmodule

// File: design/fp_ctl_pkg.sv
// sequencer, loop counter and control word types; widths come from fp_control_params.svh
`include "fp_control_params.svh"

package fp_ctl_pkg;

	// ------------------------------------------------------------
	// phase state
	// ------------------------------------------------------------

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOAD,
		S_ALIGN,
		S_ARITH,
		S_NORM,
		S_STORE,
		S_END
	} fp_state_t;

	// LP counter value
	typedef logic [`FP_LP_BITS-1:0] lp_index_t;

	// memory word select
	typedef logic [1:0] word_sel_t;

	// status out of the LP counter
	typedef struct packed {
		lp_index_t idx;
		logic      last;
		logic      busy;
	} fp_loop_t;

	// load request into the LP counter
	typedef struct packed {
		logic      load;
		lp_index_t value;
	} lp_load_t;

	// ------------------------------------------------------------
	// control levels to the datapath
	// ------------------------------------------------------------
	typedef struct packed {
		logic      read_fp;
		logic      store_fp;
		word_sel_t word_sel;
		logic      shift_align;
		logic      arith_step;
		logic      mul_div;
		logic      shift_norm;
		logic      clear_t;
	} fp_ctl_t;

endpackage

// File: design/fp_loop_counter.sv
// LP down counter; a load wins over counting, and the count stops at zero with busy dropped
`timescale 1ns/100ps

module fp_loop_counter (
	input  logic                 got_fp,
	input  logic                 _0_f,
	input  fp_ctl_pkg::lp_load_t lp_load,
	output fp_ctl_pkg::fp_loop_t loop
);

	fp_ctl_pkg::lp_index_t idx_q;
	logic                  busy_q;
	logic                  at_zero;

	assign at_zero = (idx_q == '0);

	// ------------------------------------------------------------
	// count register
	// ------------------------------------------------------------

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			idx_q <= '0;
			busy_q <= 1'b0;
		end else if (lp_load.load) begin
			idx_q <= lp_load.value;
			busy_q <= 1'b1;
		end else if (busy_q) begin
			if (at_zero) begin
				// ran out, hold at zero
				busy_q <= 1'b0;
			end else begin
				idx_q <= idx_q - fp_ctl_pkg::lp_index_t'(1);
			end
		end
	end

	// ------------------------------------------------------------
	// status
	// ------------------------------------------------------------

	assign loop.idx = idx_q;
	// last only counts while a sequence is running
	assign loop.last = busy_q & at_zero;
	assign loop.busy = busy_q;

endmodule

// File: design/fp_op_pkg.sv
// operation and datapath condition types; condition flags are plain levels from the datapath
package fp_op_pkg;

	// ------------------------------------------------------------
	// operation code
	// ------------------------------------------------------------

	// values are the FP_OP_* macros, codes 5..7 run as normalize only
	typedef logic [2:0] op_code_t;

	// ------------------------------------------------------------
	// datapath conditions
	// ------------------------------------------------------------

	// sampled every clock, no valid qualifier
	typedef struct packed {
		// exponents are equal
		logic aligned;
		// mantissa is normalized
		logic normal;
		// mantissa is zero
		logic zero;
		// result sign
		logic sgn;
	} fp_cond_t;

	// flag count, handy for stimulus packing
	localparam int FP_COND_BITS = $bits(fp_cond_t);

	// no condition active
	localparam fp_cond_t FP_COND_NONE = '{
		aligned: 1'b0,
		normal:  1'b0,
		zero:    1'b0,
		sgn:     1'b0
	};

	// datapath already aligned and normal
	localparam fp_cond_t FP_COND_READY = '{
		aligned: 1'b1,
		normal:  1'b1,
		zero:    1'b0,
		sgn:     1'b0
	};

endpackage

// File: design/fp_state_seq.sv
// phase sequencer; efp is only sampled in idle, align and normalize wait on cond with no timeout
`timescale 1ns/100ps
`include "fp_control_params.svh"

module fp_state_seq (
	input  logic                  got_fp,
	input  logic                  _0_f,
	input  logic                  efp,
	input  fp_op_pkg::op_code_t   op,
	input  fp_op_pkg::fp_cond_t   cond,
	input  fp_ctl_pkg::fp_loop_t  loop,
	output fp_ctl_pkg::fp_state_t state,
	output fp_ctl_pkg::lp_load_t  lp_load,
	output logic                  ekc_fp
);

	fp_ctl_pkg::fp_state_t state_nx;
	fp_op_pkg::op_code_t   op_q;
	logic                  first_q;
	logic                  is_addsub;
	logic                  is_muldiv;

	// ------------------------------------------------------------
	// op class of the running job
	// ------------------------------------------------------------

	assign is_addsub = (op_q == `FP_OP_AD) || (op_q == `FP_OP_SB);
	assign is_muldiv = (op_q == `FP_OP_MW) || (op_q == `FP_OP_DW);

	// ------------------------------------------------------------
	// next phase and counter loads
	// ------------------------------------------------------------

	always_comb begin
		state_nx = state;
		lp_load = '0;
		case (state)
			fp_ctl_pkg::S_IDLE: begin
				if (efp) begin
					state_nx = fp_ctl_pkg::S_LOAD;
					lp_load.load = 1'b1;
					lp_load.value = fp_ctl_pkg::lp_index_t'(`FP_WORDS - 1);
				end
			end
			fp_ctl_pkg::S_LOAD: begin
				// last operand word fetched
				if (loop.last) begin
					if (is_addsub) begin
						state_nx = fp_ctl_pkg::S_ALIGN;
					end else if (is_muldiv) begin
						state_nx = fp_ctl_pkg::S_ARITH;
						lp_load.load = 1'b1;
						lp_load.value = fp_ctl_pkg::lp_index_t'(`FP_ITER - 1);
					end else begin
						state_nx = fp_ctl_pkg::S_NORM;
					end
				end
			end
			fp_ctl_pkg::S_ALIGN: begin
				if (cond.aligned) begin
					state_nx = fp_ctl_pkg::S_ARITH;
				end
			end
			fp_ctl_pkg::S_ARITH: begin
				// add and subtract take a single step
				if (!is_muldiv || loop.last) begin
					state_nx = fp_ctl_pkg::S_NORM;
				end
			end
			fp_ctl_pkg::S_NORM: begin
				// a zero mantissa is only looked at on entry
				if (cond.normal || (first_q && cond.zero)) begin
					state_nx = fp_ctl_pkg::S_STORE;
					lp_load.load = 1'b1;
					lp_load.value = fp_ctl_pkg::lp_index_t'(`FP_WORDS - 1);
				end
			end
			fp_ctl_pkg::S_STORE: begin
				if (loop.last) begin
					state_nx = fp_ctl_pkg::S_END;
				end
			end
			fp_ctl_pkg::S_END: begin
				state_nx = fp_ctl_pkg::S_IDLE;
			end
			default: begin
				state_nx = fp_ctl_pkg::S_IDLE;
			end
		endcase
	end

	// ------------------------------------------------------------
	// phase register
	// ------------------------------------------------------------

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			state <= fp_ctl_pkg::S_IDLE;
			first_q <= 1'b0;
			op_q <= `FP_OP_AD;
		end else begin
			state <= state_nx;
			// high on the first cycle of every phase
			first_q <= (state_nx != state);
			if ((state == fp_ctl_pkg::S_IDLE) && efp) begin
				op_q <= op;
			end
		end
	end

	// one cycle end of job pulse
	assign ekc_fp = (state == fp_ctl_pkg::S_END);

endmodule

// File: fp_control.f
+incdir+design
design/fp_op_pkg.sv
design/fp_ctl_pkg.sv
design/fp_state_seq.sv
design/fp_loop_counter.sv
design/fp_control_decode.sv
design/fp_control_top.sv
bench/fp_control_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the fp control testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
	-f fp_control.f --top-module fp_control_tb -o fp_control_sim \
	> build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/fp_control_sim > sim.log 2>&1 \
	|| { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0
